/* compile.f */
logic/cpuPkg.sv
logic/displayPkg.sv
logic/regFile.sv
logic/aluCore.sv
logic/cpuCore.sv
logic/resultFifo.sv
logic/segDecoder.sv
logic/displayDriver.sv
logic/cpuDisplayTop.sv
verif/cpuDisplayTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f compile.f --top-module cpuDisplayTb -o cpuDisplayTb
./obj_dir/cpuDisplayTb > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "Simulation reported failures, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"

/* verif/cpuDisplayTb.sv */
`timescale 1ns/1ps

module cpuDisplayTb;

	import cpuPkg::*;

	localparam int DISPLAY_PERIOD = 16; // Cycles between display ticks
	localparam int FIFO_ENTRIES = 8;
	localparam int PACED_COUNT = 24;
	localparam int BURSTS = 2;
	localparam int OVERFLOW_BURST = 12;
	localparam longint TOTAL_CYCLES = 40 + 504 + 336 + 200 + 80;
	localparam longint WATCHDOG_NS = TOTAL_CYCLES * 3 / 2 * 100; // Test length plus half

	// LOADI 01h and 80h, SUB that wraps, then SHL and SHR of its result
	localparam logic [15:0] WRAP_AND_SHIFT [5] = '{16'h6101, 16'h6280, 16'h1312, 16'h7430,
		16'h8530};

	logic clk;
	logic rst;
	instrFields instr;
	logic instrStrobe;
	logic [6:0] digit3;
	logic [6:0] digit2;
	logic [6:0] digit1;
	logic [6:0] digit0;
	logic overflow;

	logic [31:0] seed;
	int checkCount = 0;
	int errCount = 0;
	int testChecks = 0;
	int testErrs = 0;
	int testsRun = 0;
	int testsFailed = 0;

	// Reference model state
	logic [15:0] modelRegs [16];
	logic [15:0] modelQ [$];
	logic [15:0] modelShown;
	logic [15:0] pendValue;
	logic pendStrobe;
	logic modelOverflow;
	logic checkDue;
	int modelTick;
	int popCount = 0;

	cpuDisplayTop DUT
	(
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instrStrobe (instrStrobe),
		.digit3      (digit3),
		.digit2      (digit2),
		.digit1      (digit1),
		.digit0      (digit0),
		.overflow    (overflow)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Mode 0 result ops only, 1 mostly LOADI, 2 any code including NOPs
	function automatic logic [15:0] randomWord(input logic [31:0] r, input int mode);
		logic [15:0] w;
		w = r[15:0];
		if (mode == 2)
			w[15:12] = r[19:16];
		else if (mode == 1 && r[21:20] != 2'b00)
			w[15:12] = 4'd6;
		else
			w[15:12] = r[19:16] % 4'd9;
		return w;
	endfunction

	function automatic logic [15:0] expectedValue(input logic [15:0] w, input logic [15:0] a,
		input logic [15:0] b);
		case (w[15:12])
			4'd0: return a + b;
			4'd1: return a - b; // Wraps modulo 2^16
			4'd2: return a & b;
			4'd3: return a | b;
			4'd4: return a ^ b;
			4'd5: return a;
			4'd6: return {8'h00, w[7:0]};
			4'd7: return {a[14:0], 1'b0};
			4'd8: return {1'b0, a[15:1]};
			default: return 16'h0000;
		endcase
	endfunction

	// Active-low pattern, gfedcba
	function automatic logic [6:0] segFor(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'b0111111;
			4'h1: lit = 7'b0000110;
			4'h2: lit = 7'b1011011;
			4'h3: lit = 7'b1001111;
			4'h4: lit = 7'b1100110;
			4'h5: lit = 7'b1101101;
			4'h6: lit = 7'b1111101;
			4'h7: lit = 7'b0000111;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1100111;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b1111100;
			4'hC: lit = 7'b1011000;
			4'hD: lit = 7'b1011110;
			4'hE: lit = 7'b1111001;
			default: lit = 7'b1110001;
		endcase
		return ~lit;
	endfunction

	task automatic compareValue(input string name, input logic [15:0] exp, input logic [15:0] act);
		checkCount++;
		if (exp !== act)
		begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errCount++;
		end
	endtask

	task automatic compareCount(input string what, input int exp, input int got);
		checkCount++;
		if (exp != got)
		begin
			$display("Wrong number of %s: expected %0d, saw %0d", what, exp, got);
			errCount++;
		end
	endtask

	task automatic checkDigits(input logic [15:0] value);
		compareValue("digit3", {9'd0, segFor(value[15:12])}, {9'd0, digit3});
		compareValue("digit2", {9'd0, segFor(value[11:8])}, {9'd0, digit2});
		compareValue("digit1", {9'd0, segFor(value[7:4])}, {9'd0, digit1});
		compareValue("digit0", {9'd0, segFor(value[3:0])}, {9'd0, digit0});
	endtask

	// Mirrors CPU, FIFO and tick counter one edge at a time
	always @(posedge clk)
	begin
		logic [15:0] w;
		logic full;
		w = instr;
		if (!rst)
		begin
			for (int i = 0; i < 16; i++)
				modelRegs[i] = 16'h0000;
			modelQ.delete();
			modelShown = 16'h0000;
			modelOverflow = 1'b0;
			pendStrobe = 1'b0;
			checkDue = 1'b0;
			modelTick = 0;
		end
		else
		begin
			checkDue = (modelTick == DISPLAY_PERIOD - 1);
			full = (modelQ.size() == FIFO_ENTRIES); // Before the pop, so a pop makes no room
			if (checkDue && modelQ.size() != 0)
			begin
				modelShown = modelQ.pop_front();
			end
			if (pendStrobe)
			begin
				if (full)
					modelOverflow = 1'b1;
				else
					modelQ.push_back(pendValue);
			end
			modelTick = checkDue ? 0 : modelTick + 1;
			pendStrobe = 1'b0;
			if (instrStrobe && w[15:12] <= 4'd8)
			begin
				pendValue = expectedValue(w, modelRegs[w[7:4]], modelRegs[w[3:0]]);
				modelRegs[w[11:8]] = pendValue;
				pendStrobe = 1'b1;
			end
		end
	end

	// Values the DUT takes from its FIFO
	always @(posedge clk)
	begin
		if (rst && DUT.pop)
			popCount++;
	end

	always @(negedge clk)
	begin
		if (checkDue)
		begin
			checkDigits(modelShown); // Cycle after each tick
			compareValue("overflow", {15'd0, modelOverflow}, {15'd0, overflow});
		end
	end

	task automatic applyReset();
		rst <= 1'b0;
		instrStrobe <= 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic issue(input logic [15:0] w);
		instr <= instrFields'(w);
		instrStrobe <= 1'b1;
		@(posedge clk);
	endtask

	task automatic idle(input int n);
		instrStrobe <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	// Returns on the edge right after a tick cycle
	task automatic waitTick();
		@(negedge clk);
		while (modelTick != DISPLAY_PERIOD - 1)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic waitDrained();
		instrStrobe <= 1'b0;
		@(negedge clk);
		while (modelQ.size() != 0 || pendStrobe)
			@(negedge clk);
		waitTick(); // One more period with the last value held
		@(negedge clk);
		@(posedge clk);
	endtask

	task automatic finishTest(input string name);
		int c;
		int e;
		c = checkCount - testChecks;
		e = errCount - testErrs;
		$display("Test %s finished: %0d checks, %0d errors", name, c, e);
		testsRun++;
		if (e != 0)
			testsFailed++;
		testChecks = checkCount;
		testErrs = errCount;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run took longer than the tests allow");
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		int startPops;
		int expected;
		logic [15:0] w;
		clk = 1'b0;
		rst = 1'b0;
		instr = instrFields'(16'h0000);
		instrStrobe = 1'b0;
		seed = 32'ha7dd;
		applyReset();

		@(negedge clk);
		checkDigits(16'h0000);
		compareValue("overflow", 16'h0000, {15'd0, overflow});
		@(posedge clk);
		waitTick();
		waitTick();
		finishTest("after reset");

		for (int i = 0; i < PACED_COUNT; i++)
		begin
			seed = xorshift(seed);
			issue(randomWord(seed, (i < 8) ? 1 : 0)); // Fill registers early
			idle(DISPLAY_PERIOD - 1);
		end
		for (int i = 0; i < 5; i++)
		begin
			issue(WRAP_AND_SHIFT[i]);
			idle(DISPLAY_PERIOD - 1);
		end
		waitDrained();
		finishTest("paced program");

		for (int b = 0; b < BURSTS; b++)
		begin
			startPops = popCount;
			expected = 0;
			for (int i = 0; i < FIFO_ENTRIES; i++)
			begin
				seed = xorshift(seed);
				w = randomWord(seed, 2);
				if (w[15:12] <= 4'd8)
					expected++;
				issue(w);
			end
			waitDrained();
			compareCount("values shown after burst", expected, popCount - startPops);
		end
		finishTest("burst");

		waitTick(); // All writes land before the next tick
		startPops = popCount;
		for (int i = 0; i < OVERFLOW_BURST; i++)
		begin
			seed = xorshift(seed);
			issue(randomWord(seed, 0));
		end
		waitDrained();
		compareCount("values shown after overflow", FIFO_ENTRIES, popCount - startPops);
		compareValue("overflow", 16'h0001, {15'd0, overflow});
		finishTest("overflow");

		applyReset();
		@(negedge clk);
		checkDigits(16'h0000);
		compareValue("overflow", 16'h0000, {15'd0, overflow});
		@(posedge clk);
		startPops = popCount;
		seed = xorshift(seed);
		issue({4'd5, seed[3:0], seed[7:4], seed[11:8]});
		waitDrained();
		@(negedge clk);
		compareCount("values shown after MOV", 1, popCount - startPops);
		checkDigits(16'h0000);
		finishTest("reset in mid-run");

		$display("Tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
			checkCount, errCount);
		if (errCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* logic/cpuDisplayTop.sv */
`timescale 1ns/1ps

module cpuDisplayTop
(
	input  logic                  clk,
	input  logic                  rst,
	input  cpuPkg::instrFields    instr,
	input  logic                  instrStrobe,
	output displayPkg::segPattern digit3,
	output displayPkg::segPattern digit2,
	output displayPkg::segPattern digit1,
	output displayPkg::segPattern digit0,
	output logic                  overflow
);

	import cpuPkg::*;

	cpuWord result;
	logic resultStrobe;
	cpuWord head;
	logic empty;
	logic pop;

	cpuCore cpu
	(
		.clk          (clk),
		.rst          (rst),
		.instr        (instr),
		.instrStrobe  (instrStrobe),
		.result       (result),
		.resultStrobe (resultStrobe)
	);

	resultFifo fifo
	(
		.clk      (clk),
		.rst      (rst),
		.wrData   (result),
		.wrEn     (resultStrobe), // No back-pressure toward the CPU
		.rdEn     (pop),
		.head     (head),
		.empty    (empty),
		.overflow (overflow)
	);

	displayDriver display
	(
		.clk    (clk),
		.rst    (rst),
		.head   (head),
		.empty  (empty),
		.pop    (pop),
		.digit3 (digit3),
		.digit2 (digit2),
		.digit1 (digit1),
		.digit0 (digit0)
	);

endmodule

/* logic/displayDriver.sv */
`timescale 1ns/1ps

module displayDriver
(
	input  logic                  clk,
	input  logic                  rst,
	input  cpuPkg::cpuWord        head,
	input  logic                  empty,
	output logic                  pop,
	output displayPkg::segPattern digit3,
	output displayPkg::segPattern digit2,
	output displayPkg::segPattern digit1,
	output displayPkg::segPattern digit0
);

	import cpuPkg::*;
	import displayPkg::*;

	logic [TICK_W-1:0] tickCount;
	logic tick;
	cpuWord shown;

	// Stands in for the slow display clock
	assign tick = tickCount == TICK_W'(DISPLAY_TICKS - 1);
	assign pop = tick && !empty;

	always_ff @(posedge clk)
	begin
		if (!rst)
			tickCount <= '0;
		else if (tick)
			tickCount <= '0;
		else
			tickCount <= tickCount + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			shown <= '0; // Blank start shows 0000
		else if (pop)
			shown <= head; // Held until the next pop
	end

	segDecoder dec3
	(
		.nibble   (shown[15:12]), // Leftmost digit
		.segments (digit3)
	);

	segDecoder dec2
	(
		.nibble   (shown[11:8]),
		.segments (digit2)
	);

	segDecoder dec1
	(
		.nibble   (shown[7:4]),
		.segments (digit1)
	);

	segDecoder dec0
	(
		.nibble   (shown[3:0]),
		.segments (digit0)
	);

endmodule

/* logic/segDecoder.sv */
`timescale 1ns/1ps

module segDecoder
(
	input  logic [3:0]            nibble,
	output displayPkg::segPattern segments
);

	import displayPkg::*;

	segPattern lit;

	always_comb
	begin
		lit = SEG_TABLE[nibble]; // Ones mark lit segments
	end

	// Common-anode digits, a segment lights on a low pin
	assign segments = ~lit;

endmodule

/* logic/resultFifo.sv */
`timescale 1ns/1ps

module resultFifo
(
	input  logic           clk,
	input  logic           rst,
	input  cpuPkg::cpuWord wrData,
	input  logic           wrEn,
	input  logic           rdEn,
	output cpuPkg::cpuWord head,
	output logic           empty,
	output logic           overflow
);

	import cpuPkg::*;
	import displayPkg::*;

	cpuWord mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wrPtr;
	logic [FIFO_PTR_W-1:0] rdPtr;
	logic [FIFO_PTR_W:0] count; // One extra bit to hold the full count
	logic full;
	logic doWrite;
	logic doRead;

	assign full = count == (FIFO_PTR_W + 1)'(FIFO_DEPTH);
	assign empty = count == '0;
	assign doWrite = wrEn && !full; // A pop in the same cycle does not make room
	assign doRead = rdEn && !empty;
	assign head = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1; // Wraps at depth
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count;
			endcase
			if (wrEn && full)
				overflow <= 1'b1; // Sticky until reset
		end
	end

	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

	// The display side must only pop what is there
	noReadWhenEmpty: assert property (@(posedge clk) disable iff (!rst)
		rdEn |-> !empty);

endmodule

/* logic/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore
(
	input  logic               clk,
	input  logic               rst,
	input  cpuPkg::instrFields instr,
	input  logic               instrStrobe,
	output cpuPkg::cpuWord     result,
	output logic               resultStrobe
);

	import cpuPkg::*;

	cpuWord srcA;
	cpuWord srcB;
	cpuWord aluOut;
	logic writesRd;
	logic doWrite;

	assign doWrite = instrStrobe && writesRd; // NOPs never write back

	regFile regs
	(
		.clk       (clk),
		.rst       (rst),
		.readAddrA (instr.rs),
		.readAddrB (instr.rt),
		.readDataA (srcA),
		.readDataB (srcB),
		.writeEn   (doWrite),
		.writeAddr (instr.rd),
		.writeData (aluOut)
	);

	aluCore alu
	(
		.op       (instr.op),
		.srcA     (srcA),
		.srcB     (srcB),
		.immByte  ({instr.rs, instr.rt}),
		.aluOut   (aluOut),
		.writesRd (writesRd)
	);

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			resultStrobe <= 1'b0;
		end
		else
		begin
			resultStrobe <= doWrite; // Pulse one cycle after the strobe
		end
	end

	always_ff @(posedge clk)
	begin
		if (doWrite)
		begin
			result <= aluOut; // Same value the register took
		end
	end

	// Checked against the raw opcode, not the ALU's own decode
	nopGivesNoResult: assert property (@(posedge clk) disable iff (!rst)
		instrStrobe && (instr.op > OP_SHR) |=> !resultStrobe);

endmodule

/* logic/aluCore.sv */
`timescale 1ns/1ps

module aluCore
(
	input  cpuPkg::opCode  op,
	input  cpuPkg::cpuWord srcA,
	input  cpuPkg::cpuWord srcB,
	input  logic [7:0]     immByte,
	output cpuPkg::cpuWord aluOut,
	output logic           writesRd
);

	import cpuPkg::*;

	always_comb
	begin
		aluOut = '0;
		writesRd = 1'b1;
		case (op)
			OP_ADD:
				aluOut = srcA + srcB;
			OP_SUB:
				aluOut = srcA - srcB; // Wraps modulo 2^16
			OP_AND:
				aluOut = srcA & srcB;
			OP_OR:
				aluOut = srcA | srcB;
			OP_XOR:
				aluOut = srcA ^ srcB;
			OP_MOV:
				aluOut = srcA;
			OP_LOADI:
				aluOut = cpuWord'(immByte); // Zero extended
			OP_SHL:
				aluOut = srcA << 1;
			OP_SHR:
				aluOut = srcA >> 1; // Logical, top bit fills with 0
			default:
				writesRd = 1'b0; // NOP and unused codes
		endcase
	end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile
(
	input  logic           clk,
	input  logic           rst,
	input  cpuPkg::regAddr readAddrA,
	input  cpuPkg::regAddr readAddrB,
	output cpuPkg::cpuWord readDataA,
	output cpuPkg::cpuWord readDataB,
	input  logic           writeEn,
	input  cpuPkg::regAddr writeAddr,
	input  cpuPkg::cpuWord writeData
);

	import cpuPkg::*;

	cpuWord regs [REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < REG_COUNT; i++)
			begin
				regs[i] <= '0; // All registers start at zero
			end
		end
		else if (writeEn)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// Reads are combinational, a write shows up after its edge
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

/* logic/displayPkg.sv */
package displayPkg;

	typedef logic [6:0] segPattern; // gfedcba, active low at the pins

	localparam int DISPLAY_TICKS = 16; // Clock cycles per shown value
	localparam int TICK_W = $clog2(DISPLAY_TICKS);

	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = 3;

	// Lit segments are ones here, the decoder inverts them
	localparam segPattern SEG_TABLE [0:15] = '{
		7'b0111111, // 0
		7'b0000110, // 1
		7'b1011011, // 2
		7'b1001111, // 3
		7'b1100110, // 4
		7'b1101101, // 5
		7'b1111101, // 6
		7'b0000111, // 7
		7'b1111111, // 8
		7'b1100111, // 9
		7'b1110111, // A
		7'b1111100, // b
		7'b1011000, // c
		7'b1011110, // d
		7'b1111001, // E
		7'b1110001  // F
	};

endpackage

/* logic/cpuPkg.sv */
package cpuPkg;

	localparam int WORD_W = 16;
	localparam int REG_ADDR_W = 4;
	localparam int REG_COUNT = 16; // One register per 4-bit index

	typedef logic [WORD_W-1:0] cpuWord;
	typedef logic [REG_ADDR_W-1:0] regAddr;

	// Codes above OP_SHR decode as no operation
	typedef enum logic [3:0]
	{
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_AND   = 4'd2,
		OP_OR    = 4'd3,
		OP_XOR   = 4'd4,
		OP_MOV   = 4'd5,
		OP_LOADI = 4'd6, // Immediate byte from rs:rt
		OP_SHL   = 4'd7,
		OP_SHR   = 4'd8,
		OP_NOP   = 4'd15
	} opCode;

	typedef struct packed
	{
		opCode  op; // Bits 15:12
		regAddr rd; // Destination
		regAddr rs; // First source, high immediate nibble
		regAddr rt; // Second source, low immediate nibble
	} instrFields;

endpackage
